// File: rtl/nobl_bus_pkg.sv
// SRAM address and data bus widths with their vector types

package nobl_bus_pkg;

   // Word address into the SRAM array, 512K words
   localparam int ADDR_W = 19;

   // One data word including the two parity-capable bits
   localparam int DATA_W = 18;

   // Address as it appears on ram_a
   typedef logic [ADDR_W-1:0] ram_addr_t;

   // Data word as carried on the shared bus and the client ports
   typedef logic [DATA_W-1:0] ram_data_t;

endpackage

// File: rtl/nobl_pipe_pkg.sv
// Pipeline timing constants of the NoBL SRAM controller

package nobl_pipe_pkg;

   // Cycles from address phase to write data on the pins
   localparam int WR_DATA_LAG = 2;

   // Cycles from address phase until the SRAM drives read data
   localparam int SRAM_RD_LAG = 2;

   // Request edge to rdata_valid
   // One cycle to the address phase, the SRAM lag, then the capture register
   localparam int RD_LATENCY = 1 + SRAM_RD_LAG + 1;

endpackage

// File: rtl/nobl_cmd_stage.sv
// Command issue stage driving address, write enable and chip select

module nobl_cmd_stage
(
   input  logic                    clk,
   input  logic                    rst,
   input  nobl_bus_pkg::ram_addr_t address,
   input  nobl_bus_pkg::ram_data_t wdata,
   input  logic                    write,
   input  logic                    enable,
   output nobl_bus_pkg::ram_addr_t ram_a,
   output logic                    ram_we_n,
   output logic                    ram_ce1_n,
   output logic                    cmd_enable,
   output logic                    cmd_write,
   output nobl_bus_pkg::ram_data_t cmd_wdata
);

   // Control bits of the address phase
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ram_ce1_n  <= 1'b1;
         ram_we_n   <= 1'b1;
         cmd_enable <= 1'b0;
         cmd_write  <= 1'b0;
      end
      else
      begin
         cmd_enable <= enable;
         ram_ce1_n  <= ~enable;        // Kept as a pad flop
         if (enable)
         begin
            cmd_write <= write;
            ram_we_n  <= ~write;       // Pad flop as well
         end
      end
   end

   // Address holds its last value while the client is idle
   always_ff @(posedge clk)
   begin
      if (enable)
         ram_a <= address;
   end

   // Write data is only of interest for writes
   always_ff @(posedge clk)
   begin
      if (enable && write)
         cmd_wdata <= wdata;
   end

endmodule

// File: rtl/nobl_wdata_stage.sv
// Write-data delay and bus output enable for the NoBL SRAM controller

module nobl_wdata_stage
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    cmd_enable,
   input  logic                    cmd_write,
   input  nobl_bus_pkg::ram_data_t cmd_wdata,
   output nobl_bus_pkg::ram_data_t ram_d_out,
   output logic                    ram_d_oen,
   output logic                    op_enable,
   output logic                    op_write
);

   import nobl_bus_pkg::*;
   import nobl_pipe_pkg::*;

   // Index 0 is stage 2, the last index is stage 3
   logic      en_q   [WR_DATA_LAG];
   logic      wr_q   [WR_DATA_LAG];
   ram_data_t data_q [WR_DATA_LAG];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < WR_DATA_LAG; i++)
         begin
            en_q[i] <= 1'b0;
            wr_q[i] <= 1'b0;
         end
         ram_d_oen <= 1'b1;            // Bus released
      end
      else
      begin
         en_q[0] <= cmd_enable;
         wr_q[0] <= cmd_write;
         for (int i = 1; i < WR_DATA_LAG; i++)
         begin
            en_q[i] <= en_q[i-1];
            wr_q[i] <= wr_q[i-1];
         end
         // Decoded one stage early so enable and data switch on the same edge
         ram_d_oen <= ~(en_q[WR_DATA_LAG-2] & wr_q[WR_DATA_LAG-2]);
      end
   end

   always_ff @(posedge clk)
   begin
      data_q[0] <= cmd_wdata;
      for (int i = 1; i < WR_DATA_LAG; i++)
         data_q[i] <= data_q[i-1];
   end

   // The bus is driven only while ram_d_oen is low, so a read
   // followed directly by a write needs no idle cycle
   assign ram_d_out = data_q[WR_DATA_LAG-1];

   assign op_enable = en_q[WR_DATA_LAG-1];
   assign op_write  = wr_q[WR_DATA_LAG-1];

endmodule

// File: rtl/nobl_rdata_stage.sv
// Read capture stage with read-valid generation

module nobl_rdata_stage
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    op_enable,
   input  logic                    op_write,
   input  nobl_bus_pkg::ram_data_t ram_d_in,
   output nobl_bus_pkg::ram_data_t rdata,
   output logic                    rdata_valid
);

   import nobl_pipe_pkg::*;

   // Ops arrive WR_DATA_LAG after the address phase, read data SRAM_RD_LAG after it
   localparam int ALIGN = SRAM_RD_LAG - WR_DATA_LAG;

   logic rd_hit;   // Enabled read whose data is on the bus now

   generate
      if (ALIGN == 0)
      begin : g_direct
         assign rd_hit = op_enable & ~op_write;
      end
      else
      begin : g_delay
         logic [ALIGN:0] rd_q;

         assign rd_q[0] = op_enable & ~op_write;

         always_ff @(posedge clk)
         begin
            if (rst)
               rd_q[ALIGN:1] <= '0;
            else
               rd_q[ALIGN:1] <= rd_q[ALIGN-1:0];
         end

         assign rd_hit = rd_q[ALIGN];
      end
   endgenerate

   always_ff @(posedge clk)
   begin
      if (rst)
         rdata_valid <= 1'b0;
      else
         rdata_valid <= rd_hit;
   end

   // Bus sampled every cycle, only meaningful with rdata_valid
   always_ff @(posedge clk)
   begin
      rdata <= ram_d_in;
   end

endmodule

// File: rtl/nobl_sram_ctrl.sv
// Top level of the NoBL SRAM controller with the static SRAM pin ties

module nobl_sram_ctrl
(
   input  logic                    clk,
   input  logic                    rst,

   // Client request
   input  nobl_bus_pkg::ram_addr_t address,
   input  nobl_bus_pkg::ram_data_t wdata,
   input  logic                    write,
   input  logic                    enable,

   // Client read return, no back-pressure
   output nobl_bus_pkg::ram_data_t rdata,
   output logic                    rdata_valid,

   // SRAM pins
   output nobl_bus_pkg::ram_addr_t ram_a,
   output logic                    ram_we_n,
   output logic                    ram_ce1_n,
   output logic                    ram_cen_n,
   output logic                    ram_ld_n,
   output logic                    ram_oe_n,
   input  nobl_bus_pkg::ram_data_t ram_d_in,
   output nobl_bus_pkg::ram_data_t ram_d_out,
   output logic                    ram_d_oen   // Active low, drives ram_d_out onto the bus
);

   import nobl_bus_pkg::*;

   logic      cmd_enable;
   logic      cmd_write;
   ram_data_t cmd_wdata;

   logic      op_enable;   // Stage 3 op, lined up with the read data
   logic      op_write;

   // Clock always enabled, no bursts, output timing left to the SRAM
   assign ram_cen_n = 1'b0;
   assign ram_ld_n  = 1'b0;
   assign ram_oe_n  = 1'b0;

   nobl_cmd_stage nobl_cmd_stage_inst
   (
      .clk        (clk),
      .rst        (rst),
      .address    (address),
      .wdata      (wdata),
      .write      (write),
      .enable     (enable),
      .ram_a      (ram_a),
      .ram_we_n   (ram_we_n),
      .ram_ce1_n  (ram_ce1_n),
      .cmd_enable (cmd_enable),
      .cmd_write  (cmd_write),
      .cmd_wdata  (cmd_wdata)
   );

   nobl_wdata_stage nobl_wdata_stage_inst
   (
      .clk        (clk),
      .rst        (rst),
      .cmd_enable (cmd_enable),
      .cmd_write  (cmd_write),
      .cmd_wdata  (cmd_wdata),
      .ram_d_out  (ram_d_out),
      .ram_d_oen  (ram_d_oen),
      .op_enable  (op_enable),
      .op_write   (op_write)
   );

   nobl_rdata_stage nobl_rdata_stage_inst
   (
      .clk         (clk),
      .rst         (rst),
      .op_enable   (op_enable),
      .op_write    (op_write),
      .ram_d_in    (ram_d_in),
      .rdata       (rdata),
      .rdata_valid (rdata_valid)
   );

endmodule

// File: verification/nobl_sram_model.sv
// Behavioral NoBL SRAM with pipelined read and write timing and a bus contention flag

module nobl_sram_model
(
   input  logic                    clk,
   input  nobl_bus_pkg::ram_addr_t ram_a,
   input  logic                    ram_we_n,
   input  logic                    ram_ce1_n,
   input  logic                    ram_d_oen,
   input  nobl_bus_pkg::ram_data_t dq_in,
   output nobl_bus_pkg::ram_data_t dq_out,
   output logic                    dq_drive,
   output logic                    contention
);

   import nobl_bus_pkg::*;
   import nobl_pipe_pkg::*;

   localparam int DEPTH = (WR_DATA_LAG > SRAM_RD_LAG) ? WR_DATA_LAG : SRAM_RD_LAG;

   ram_data_t mem [ram_addr_t];     // Written words only
   logic      vld_p  [DEPTH];       // Index i was sampled i+1 edges ago
   logic      wr_p   [DEPTH];
   ram_addr_t addr_p [DEPTH];

   // Power-up contents, every address bit takes part
   function automatic ram_data_t fill_word(input ram_addr_t a);
      return ram_data_t'(a) ^ ram_data_t'(a >> 1) ^ ram_data_t'('h2_5a5a);
   endfunction

   initial
   begin
      for (int i = 0; i < DEPTH; i++)
         vld_p[i] = 1'b0;
      dq_drive = 1'b0;
   end

   always @(posedge clk)
   begin
      // Commit first so a read right behind a write sees the new word
      if (vld_p[WR_DATA_LAG-1] && wr_p[WR_DATA_LAG-1])
         mem[addr_p[WR_DATA_LAG-1]] = dq_in;
      if (vld_p[SRAM_RD_LAG-2] && !wr_p[SRAM_RD_LAG-2])
      begin
         dq_drive <= 1'b1;             // Valid at the following edge
         dq_out   <= mem.exists(addr_p[SRAM_RD_LAG-2]) ? mem[addr_p[SRAM_RD_LAG-2]]
                                                       : fill_word(addr_p[SRAM_RD_LAG-2]);
      end
      else
         dq_drive <= 1'b0;
      vld_p[0]  <= !ram_ce1_n;
      wr_p[0]   <= !ram_we_n;
      addr_p[0] <= ram_a;
      for (int i = 1; i < DEPTH; i++)
      begin
         vld_p[i]  <= vld_p[i-1];
         wr_p[i]   <= wr_p[i-1];
         addr_p[i] <= addr_p[i-1];
      end
   end

   assign contention = dq_drive && !ram_d_oen;   // Both sides on the bus

endmodule

// File: verification/nobl_sram_ctrl_tb.sv
// Testbench for the NoBL SRAM controller with SRAM model, reference memory and assertions

module nobl_sram_ctrl_tb;

   import nobl_bus_pkg::*;
   import nobl_pipe_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 16;
   localparam int RUN_LEN      = 200;
   localparam int TEST_CYCLES  = 8 + 40 + 8 + RUN_LEN + 40 + 12;
   localparam int DRAIN_CYCLES = 2 * RD_LATENCY + 2;
   localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + TEST_CYCLES + 6 * DRAIN_CYCLES);
   localparam ram_addr_t RUN_BASE = 19'h5_a3c0;   // Small window for address reuse

   logic      clk = 1'b0;
   logic      rst;
   ram_addr_t address;
   ram_data_t wdata;
   logic      write;
   logic      enable;
   ram_data_t rdata;
   logic      rdata_valid;
   ram_addr_t ram_a;
   logic      ram_we_n;
   logic      ram_ce1_n;
   logic      ram_cen_n;
   logic      ram_ld_n;
   logic      ram_oe_n;
   ram_data_t ram_d_out;
   logic      ram_d_oen;
   ram_data_t ram_dq;
   ram_data_t model_dq;
   logic      model_drive;
   logic      contention;

   ram_data_t   ref_mem [ram_addr_t];
   ram_data_t   exp_q [$];            // Read results in request order
   ram_data_t   exp_data;
   logic        exp_avail;
   logic        hist_en    [RD_LATENCY];   // Index k is the request k+1 edges back
   logic        hist_wr    [RD_LATENCY];
   ram_data_t   hist_wdata [RD_LATENCY];
   ram_addr_t   last_addr;
   logic        rst_d = 1'b0;
   logic [31:0] lcg_state = 32'h3614_0c8e;
   int          errors = 0;
   int          err_mark = 0;
   int          test_count = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   nobl_sram_ctrl nobl_sram_ctrl_inst (.*, .ram_d_in(ram_dq));

   nobl_sram_model nobl_sram_model_inst
   (
      .clk        (clk),
      .ram_a      (ram_a),
      .ram_we_n   (ram_we_n),
      .ram_ce1_n  (ram_ce1_n),
      .ram_d_oen  (ram_d_oen),
      .dq_in      (ram_dq),
      .dq_out     (model_dq),
      .dq_drive   (model_drive),
      .contention (contention)
   );

   // Shared bus goes to x while both sides drive
   assign ram_dq = (!ram_d_oen && model_drive) ? 'x :
                   !ram_d_oen                  ? ram_d_out :
                   model_drive                 ? model_dq : 'z;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // SRAM power-up contents by the model's rule
   function automatic ram_data_t power_up_word(input ram_addr_t a);
      return ram_data_t'(a) ^ ram_data_t'(a >> 1) ^ ram_data_t'('h2_5a5a);
   endfunction

   function automatic ram_data_t ref_word(input ram_addr_t a);
      if (ref_mem.exists(a))
         return ref_mem[a];
      return power_up_word(a);
   endfunction

   task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
      errors++;
      $display("error %s: got %h expected %h at %0t", name, got, exp, $time);
   endtask

   task automatic plain_error(input string what);
      errors++;
      $display("%s at %0t", what, $time);
   endtask

   task automatic issue(input logic wr, input ram_addr_t a, input ram_data_t d);
      @(posedge clk);
      enable  <= 1'b1;
      write   <= wr;
      address <= a;
      wdata   <= d;
      if (wr)
         ref_mem[a] = d;
      else
         exp_q.push_back(ref_word(a));
   endtask

   task automatic idle_cycles(input int n);
      logic [31:0] r;
      repeat (n)
      begin
         @(posedge clk);
         r = lcg_next();
         enable  <= 1'b0;
         write   <= r[31];
         address <= ram_addr_t'(r);   // Ignored by the DUT while idle
      end
   endtask

   task automatic drain_reads();
      idle_cycles(1);
      while (exp_q.size() != 0)
         @(posedge clk);
      idle_cycles(RD_LATENCY + 1);   // Room for a stray valid pulse
   endtask

   task automatic finish_test(input string name);
      test_count++;
      if (errors == err_mark)
         $display("test %0d %s: ok", test_count, name);
      else
         $display("test %0d %s: %0d errors", test_count, name, errors - err_mark);
      err_mark = errors;
   endtask

   always @(posedge clk)
   begin
      hist_en[0]    <= enable;
      hist_wr[0]    <= write;
      hist_wdata[0] <= wdata;
      for (int i = 1; i < RD_LATENCY; i++)
      begin
         hist_en[i]    <= hist_en[i-1];
         hist_wr[i]    <= hist_wr[i-1];
         hist_wdata[i] <= hist_wdata[i-1];
      end
      if (enable)
         last_addr <= address;
      rst_d <= rst;
      if (!rst && rdata_valid && exp_q.size() != 0)
         void'(exp_q.pop_front());
   end

   // Front of the queue is stable before the next sampling edge
   always @(negedge clk)
   begin
      exp_avail = (exp_q.size() != 0);
      exp_data  = exp_avail ? exp_q[0] : '0;
   end

   reset_chk: assert property (@(posedge clk)
      rst_d |-> {ram_ce1_n, ram_we_n, ram_d_oen, rdata_valid} == 4'b1110)
      else value_error("ce1_n/we_n/d_oen/rdata_valid",
                       $sampled({ram_ce1_n, ram_we_n, ram_d_oen, rdata_valid}), 4'b1110);
   static_chk: assert property (@(posedge clk) {ram_cen_n, ram_ld_n, ram_oe_n} == 3'b000)
      else value_error("cen_n/ld_n/oe_n", $sampled({ram_cen_n, ram_ld_n, ram_oe_n}), 0);
   ce_chk: assert property (@(posedge clk) disable iff (rst) ram_ce1_n == !hist_en[0])
      else value_error("ram_ce1_n", $sampled(ram_ce1_n), $sampled(!hist_en[0]));
   we_chk: assert property (@(posedge clk) disable iff (rst)
      hist_en[0] |-> ram_we_n == !hist_wr[0])
      else value_error("ram_we_n", $sampled(ram_we_n), $sampled(!hist_wr[0]));
   addr_chk: assert property (@(posedge clk) disable iff (rst) ram_a === last_addr)
      else value_error("ram_a", $sampled(ram_a), $sampled(last_addr));
   oen_chk: assert property (@(posedge clk) disable iff (rst)
      ram_d_oen == !(hist_en[WR_DATA_LAG] && hist_wr[WR_DATA_LAG]))
      else value_error("ram_d_oen", $sampled(ram_d_oen),
                       $sampled(!(hist_en[WR_DATA_LAG] && hist_wr[WR_DATA_LAG])));
   dout_chk: assert property (@(posedge clk) disable iff (rst)
      !ram_d_oen |-> ram_d_out == hist_wdata[WR_DATA_LAG])
      else value_error("ram_d_out", $sampled(ram_d_out), $sampled(hist_wdata[WR_DATA_LAG]));
   valid_chk: assert property (@(posedge clk) disable iff (rst)
      rdata_valid == (hist_en[RD_LATENCY-1] && !hist_wr[RD_LATENCY-1]))
      else value_error("rdata_valid", $sampled(rdata_valid),
                       $sampled(hist_en[RD_LATENCY-1] && !hist_wr[RD_LATENCY-1]));
   extra_chk: assert property (@(posedge clk) disable iff (rst) rdata_valid |-> exp_avail)
      else plain_error("read valid with no read outstanding");
   rdata_chk: assert property (@(posedge clk) disable iff (rst)
      rdata_valid && exp_avail |-> rdata == exp_data)
      else value_error("rdata", $sampled(rdata), $sampled(exp_data));
   bus_chk: assert property (@(posedge clk) disable iff (rst) !contention)
      else plain_error("bus contention between controller and SRAM model");

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout, tests did not end within %0d cycles", WATCHDOG_CYCLES);
      $display("Finished with errors");
      $finish;
   end

   initial
   begin
      ram_addr_t   a;
      logic [31:0] r;
      rst     = 1'b1;
      enable  = 1'b0;
      write   = 1'b0;
      address = '0;
      wdata   = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      idle_cycles(8);
      finish_test("reset values and static pins");

      for (int i = 0; i < 8; i++)
      begin
         issue(1'b0, ram_addr_t'(lcg_next()), '0);
         idle_cycles(2);
         issue(1'b1, ram_addr_t'(lcg_next()), ram_data_t'(lcg_next()));
         idle_cycles(1);
      end
      drain_reads();
      finish_test("read latency");

      a = ram_addr_t'(lcg_next());
      issue(1'b1, a, ram_data_t'(lcg_next()));
      issue(1'b0, a, '0);               // Read on the very next cycle
      issue(1'b1, a + 1, ram_data_t'(lcg_next()));
      idle_cycles(2);
      issue(1'b0, a + 1, '0);
      issue(1'b0, a, '0);
      drain_reads();
      finish_test("write then read back");

      for (int i = 0; i < RUN_LEN; i++)
      begin
         r = lcg_next();
         issue(r[31], RUN_BASE + ram_addr_t'(r[27:24]), ram_data_t'(lcg_next()));
      end
      drain_reads();
      finish_test("random back-to-back run");

      for (int i = 0; i < 20; i++)
      begin
         r = lcg_next();
         issue(1'b0, RUN_BASE + ram_addr_t'(r[27:24]), '0);
         issue(1'b1, RUN_BASE + ram_addr_t'(r[23:20]), ram_data_t'(lcg_next()));
      end
      drain_reads();
      finish_test("read write turnaround");

      a = ram_addr_t'(lcg_next());
      issue(1'b0, a, '0);
      idle_cycles(6);                   // Address must hold
      issue(1'b1, a, ram_data_t'(lcg_next()));
      idle_cycles(4);
      issue(1'b0, a, '0);
      drain_reads();
      finish_test("idle hold");

      $display("%0d tests, %0d errors", test_count, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// File: nobl_sram.f
rtl/nobl_bus_pkg.sv
rtl/nobl_pipe_pkg.sv
rtl/nobl_cmd_stage.sv
rtl/nobl_wdata_stage.sv
rtl/nobl_rdata_stage.sv
rtl/nobl_sram_ctrl.sv
verification/nobl_sram_model.sv
verification/nobl_sram_ctrl_tb.sv

// File: Bender.yml
package:
  name: nobl_sram

sources:
  - files:
      - rtl/nobl_bus_pkg.sv
      - rtl/nobl_pipe_pkg.sv
      - rtl/nobl_cmd_stage.sv
      - rtl/nobl_wdata_stage.sv
      - rtl/nobl_rdata_stage.sv
      - rtl/nobl_sram_ctrl.sv
  - target: test
    files:
      - verification/nobl_sram_model.sv
      - verification/nobl_sram_ctrl_tb.sv
